// File: compile.f
+incdir+testbench
verilog/pipe_pkg.sv
verilog/fetch_latch.sv
verilog/decode_latch.sv
verilog/execute_latch.sv
verilog/writeback_latch.sv
verilog/pipe_latches.sv
testbench/tb_pipe_latches.sv

// File: testbench/tb_pipe_model.svh
// latch reference model, included inside the testbench module; needs pc_initial declared first.
`ifndef TB_PIPE_MODEL_SVH
`define TB_PIPE_MODEL_SVH

typedef struct packed {
	pipe_pkg::fd_t slot;
	pipe_pkg::exc_rec_t rec;
} fd_state_t;

typedef struct packed {
	pipe_pkg::dx_t slot;
	pipe_pkg::exc_rec_t rec;
} dx_state_t;

typedef struct packed {
	pipe_pkg::xm_t slot;
	pipe_pkg::exc_rec_t rec;
} xm_state_t;

typedef struct packed {
	pipe_pkg::mw_t slot;
	pipe_pkg::exc_rec_t rec;
} mw_state_t;

function automatic logic is_tlb_miss(input pipe_pkg::word_t cause);
	return cause == pipe_pkg::exc_itlb_miss || cause == pipe_pkg::exc_dtlb_miss;
endfunction

// an older exception travels on unchanged.
function automatic pipe_pkg::exc_rec_t exc_record(input pipe_pkg::exc_rec_t rec_in,
		input pipe_pkg::exc_e exc);
	if (rec_in.cause != 32'd0)
		return rec_in;
	return {pipe_pkg::word_t'(exc), 32'd0, rec_in.epc};
endfunction

function automatic fd_state_t fd_next(input fd_state_t cur, input logic rst, input logic fl,
		input logic st, input logic ic, input pipe_pkg::exc_e exc, input pipe_pkg::fd_t in);
	fd_state_t nxt;
	nxt = cur;
	if (rst || fl || exc != pipe_pkg::exc_none) begin
		nxt = '0;
		nxt.slot.pc = pc_initial;
		nxt.slot.inst = pipe_pkg::nop_inst;
		nxt.slot.is_flush = fl && !rst;
		if (!rst && !fl) begin
			nxt.slot.psw = in.psw;
			nxt.rec = {pipe_pkg::word_t'(exc), in.pc, in.pc};
		end
	end else if (!st && ic) begin
		nxt.slot.inst = pipe_pkg::nop_inst; // pc and record hold.
	end else if (!st) begin
		nxt.slot = in;
		nxt.rec = '0;
	end
	return nxt;
endfunction

function automatic dx_state_t dx_next(input dx_state_t cur, input logic rst, input logic fl,
		input logic st, input logic hz, input pipe_pkg::exc_e exc, input pipe_pkg::dx_t in,
		input pipe_pkg::exc_rec_t rec_in);
	dx_state_t nxt;
	nxt = cur;
	if (rst || fl || exc != pipe_pkg::exc_none) begin
		nxt = '0; // all-zero control is the idle control.
		nxt.slot.pc = pc_initial;
		nxt.slot.is_flush = fl && !rst;
		if (!rst && !fl)
			nxt.rec = exc_record(rec_in, exc);
	end else if (!st) begin
		if (hz)
			nxt.slot.ctrl = pipe_pkg::ctrl_idle;
		else
			nxt.slot = in;
		nxt.rec = rec_in;
	end
	return nxt;
endfunction

function automatic xm_state_t xm_next(input xm_state_t cur, input logic rst, input logic fl,
		input logic st, input pipe_pkg::exc_e exc, input pipe_pkg::xm_t in,
		input pipe_pkg::exc_rec_t rec_in);
	xm_state_t nxt;
	nxt = cur;
	if (rst || fl || exc != pipe_pkg::exc_none) begin
		nxt = '0;
		nxt.slot.pc = pc_initial;
		nxt.slot.is_flush = fl && !rst;
		if (!rst && !fl)
			nxt.rec = exc_record(rec_in, exc);
	end else if (!st) begin
		nxt.slot = in;
		nxt.rec = rec_in;
	end
	return nxt;
endfunction

function automatic mw_state_t mw_next(input mw_state_t cur, input logic rst, input logic fl,
		input logic st, input logic ecall, input pipe_pkg::exc_e exc,
		input pipe_pkg::word_t addr, input pipe_pkg::mw_t in, input pipe_pkg::exc_rec_t rec_in);
	mw_state_t nxt;
	nxt = cur;
	if (rst || fl || exc != pipe_pkg::exc_none) begin
		nxt = '0;
		nxt.slot.is_flush = fl && !rst;
		if (!rst && !fl && rec_in.cause == pipe_pkg::exc_itlb_miss)
			nxt.rec = rec_in;
		else if (!rst && !fl && rec_in.cause == 32'd0 && is_tlb_miss(exc))
			nxt.rec = {pipe_pkg::word_t'(exc), addr, rec_in.epc};
	end else if (!st) begin
		nxt.slot = in;
		nxt.rec = ecall ? {in.result, rec_in.addr, rec_in.epc + 32'd4} : rec_in;
	end
	return nxt;
endfunction

`endif

// File: testbench/tb_pipe_latches.sv
// random test of the latches against a model; fixed seed, 2000 cycles, stops at the first mismatch.
`default_nettype none

module tb_pipe_latches;

	localparam pipe_pkg::word_t pc_initial = 32'h0000_2000;
	localparam int period = 4;
	localparam int reset_cycles = 4;
	localparam int n_cycles = 2000;

	logic clk = 1'b0;
	logic reset, flush, stall, icache_stall, hazard;
	pipe_pkg::fd_t fd_in, fd_out;
	pipe_pkg::dx_t dx_in, dx_out;
	pipe_pkg::xm_t xm_in, xm_out;
	pipe_pkg::mw_t mw_in, mw_out;
	pipe_pkg::exc_e fd_exc, dx_exc, xm_exc, mw_exc;
	pipe_pkg::word_t mem_addr;
	pipe_pkg::exc_rec_t fd_rec, dx_rec, xm_rec, mw_rec;
	integer seed;
	string test_name;

	`include "tb_pipe_model.svh"

	fd_state_t exp_fd;
	dx_state_t exp_dx;
	xm_state_t exp_xm;
	mw_state_t exp_mw;

	pipe_latches #(.pc_initial(pc_initial)) i_pipe_latches (
		.clk(clk), .reset(reset), .flush(flush), .stall(stall),
		.icache_stall(icache_stall), .hazard(hazard),
		.fd_in(fd_in), .dx_in(dx_in), .xm_in(xm_in), .mw_in(mw_in),
		.fd_exc(fd_exc), .dx_exc(dx_exc), .xm_exc(xm_exc), .mw_exc(mw_exc),
		.mem_addr(mem_addr),
		.fd_out(fd_out), .dx_out(dx_out), .xm_out(xm_out), .mw_out(mw_out),
		.fd_rec(fd_rec), .dx_rec(dx_rec), .xm_rec(xm_rec), .mw_rec(mw_rec)
	);

	always #(period / 2) clk = ~clk;

	initial begin
		#(n_cycles * period + 20 * period);
		$display("Error: run did not finish in time");
		$display("Checks failed");
		$fatal(1);
	end

	function automatic pipe_pkg::exc_e pick_exc(input logic [31:0] r_hit,
			input logic [31:0] r_kind);
		if (r_hit % 12 != 0)
			return pipe_pkg::exc_none;
		return pipe_pkg::exc_e'(1 + r_kind % 4); // any of the four causes.
	endfunction

	task check(input string what, input logic [159:0] exp, input logic [159:0] act);
		assert (act === exp) else begin
			$display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	task check_outputs();
		check("fd_out", exp_fd.slot, fd_out);
		check("fd_rec", exp_fd.rec, fd_rec);
		check("dx_out", exp_dx.slot, dx_out);
		check("dx_rec", exp_dx.rec, dx_rec);
		check("xm_out", exp_xm.slot, xm_out);
		check("xm_rec", exp_xm.rec, xm_rec);
		check("mw_out", exp_mw.slot, mw_out);
		check("mw_rec", exp_mw.rec, mw_rec);
	endtask

	task check_reset_state();
		check("fd pc", pc_initial, fd_out.pc);
		check("dx pc", pc_initial, dx_out.pc);
		check("xm pc", pc_initial, xm_out.pc);
		check("flush flags", 0,
			{fd_out.is_flush, dx_out.is_flush, xm_out.is_flush, mw_out.is_flush});
		check("enables", 0, {dx_out.ctrl.reg_write, dx_out.ctrl.mem_we, dx_out.ctrl.is_ecall,
			xm_out.reg_write, xm_out.mem_we, xm_out.is_ecall, mw_out.reg_write});
		check("records", 0, {|fd_rec, |dx_rec, |xm_rec, |mw_rec});
	endtask

	// old model state feeds every latch, like the registers do.
	task model_step();
		fd_state_t fd_n;
		dx_state_t dx_n;
		xm_state_t xm_n;
		mw_state_t mw_n;
		fd_n = fd_next(exp_fd, reset, flush, stall, icache_stall, fd_exc, fd_in);
		dx_n = dx_next(exp_dx, reset, flush, stall, hazard, dx_exc, dx_in, exp_fd.rec);
		xm_n = xm_next(exp_xm, reset, flush, stall, xm_exc, xm_in, exp_dx.rec);
		mw_n = mw_next(exp_mw, reset, flush, stall, xm_in.is_ecall, mw_exc, mem_addr, mw_in,
			exp_xm.rec);
		exp_fd = fd_n;
		exp_dx = dx_n;
		exp_xm = xm_n;
		exp_mw = mw_n;
	endtask

	task drive_inputs(input logic rst);
		logic [159:0] bits;
		reset = rst;
		flush = $unsigned($random(seed)) % 16 == 0;
		stall = $unsigned($random(seed)) % 6 == 0;
		icache_stall = $unsigned($random(seed)) % 6 == 0;
		hazard = $unsigned($random(seed)) % 6 == 0;
		fd_exc = pick_exc($random(seed), $random(seed));
		dx_exc = pick_exc($random(seed), $random(seed));
		xm_exc = pick_exc($random(seed), $random(seed));
		mw_exc = pick_exc($random(seed), $random(seed));
		mem_addr = $random(seed);
		bits = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
		fd_in = bits[$bits(pipe_pkg::fd_t)-1:0];
		bits = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
		dx_in = bits[$bits(pipe_pkg::dx_t)-1:0];
		bits = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
		xm_in = bits[$bits(pipe_pkg::xm_t)-1:0];
		bits = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
		mw_in = bits[$bits(pipe_pkg::mw_t)-1:0];
	endtask

	initial begin
		seed = 32'h3c9b;
		test_name = "reset";
		reset = 1'b1;
		{flush, stall, icache_stall, hazard} = '0;
		{fd_in, dx_in, xm_in, mw_in, mem_addr} = '0;
		fd_exc = pipe_pkg::exc_none;
		dx_exc = pipe_pkg::exc_none;
		xm_exc = pipe_pkg::exc_none;
		mw_exc = pipe_pkg::exc_none;
		{exp_fd, exp_dx, exp_xm, exp_mw} = '0;
		for (int cycle = 0; cycle < n_cycles; cycle++) begin
			@(posedge clk);
			model_step();
			@(negedge clk);
			check_outputs();
			if (cycle == reset_cycles - 1)
				check_reset_state();
			drive_inputs(cycle + 1 < reset_cycles);
			if (cycle + 1 == reset_cycles)
				test_name = "random_flow";
		end
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/decode_latch.sv
// decode/execute latch; a load-use hazard clears control only, operands stay for the replay.
`default_nettype none

module decode_latch #(
	parameter pipe_pkg::word_t pc_initial = 32'h0000_1000
) (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic stall,
	input logic hazard,
	input pipe_pkg::exc_e exc,
	input pipe_pkg::dx_t slot_in,
	input pipe_pkg::exc_rec_t rec_in,
	output pipe_pkg::dx_t slot,
	output pipe_pkg::exc_rec_t rec
);

	localparam pipe_pkg::dx_t dx_idle = '{
		pc: pc_initial,
		reg_a: 32'd0,
		reg_b: 32'd0,
		immed: 32'd0,
		ctrl: pipe_pkg::ctrl_idle,
		psw: 1'b0,
		is_flush: 1'b0
	};

	always_ff @(posedge clk) begin
		if (reset) begin
			slot <= dx_idle;
			rec <= '0;
		end else if (flush) begin
			slot <= dx_idle;
			slot.is_flush <= 1'b1;
			rec <= '0;
		end else if (exc != pipe_pkg::exc_none) begin
			slot <= dx_idle;
			rec <= pipe_pkg::forward_exc(rec_in, exc);
		end else if (!stall) begin
			if (hazard) begin
				// bubble.
				slot.ctrl <= pipe_pkg::ctrl_idle;
			end else begin
				slot <= slot_in;
			end
			rec <= rec_in;
		end
	end

endmodule

`default_nettype wire

// File: verilog/execute_latch.sv
// execute/memory latch; exceptions follow the same forward-or-start rule as the decode latch.
`default_nettype none

module execute_latch #(
	parameter pipe_pkg::word_t pc_initial = 32'h0000_1000
) (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic stall,
	input pipe_pkg::exc_e exc,
	input pipe_pkg::xm_t slot_in,
	input pipe_pkg::exc_rec_t rec_in,
	output pipe_pkg::xm_t slot,
	output pipe_pkg::exc_rec_t rec
);

	localparam pipe_pkg::xm_t xm_idle = '{
		pc: pc_initial,
		result: 32'd0,
		reg_b: 32'd0,
		rd: 5'd0,
		reg_write: 1'b0,
		mem_to_reg: 1'b0,
		mem_we: 1'b0,
		is_byte: 1'b0,
		is_ecall: 1'b0,
		psw: 1'b0,
		is_flush: 1'b0
	};

	always_ff @(posedge clk) begin
		if (reset) begin
			slot <= xm_idle;
			rec <= '0;
		end else if (flush) begin
			slot <= xm_idle;
			slot.is_flush <= 1'b1;
			rec <= '0;
		end else if (exc != pipe_pkg::exc_none) begin
			slot <= xm_idle; // no store may leave a faulting slot.
			rec <= pipe_pkg::forward_exc(rec_in, exc);
		end else if (!stall) begin
			slot <= slot_in;
			rec <= rec_in;
		end
	end

endmodule

`default_nettype wire

// File: verilog/fetch_latch.sv
// fetch/decode latch; flush beats exception beats stall, and an icache miss only swaps in a no-op.
`default_nettype none

module fetch_latch #(
	parameter pipe_pkg::word_t pc_initial = 32'h0000_1000
) (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic stall,
	input logic icache_stall,
	input pipe_pkg::exc_e exc,
	input pipe_pkg::fd_t slot_in,
	output pipe_pkg::fd_t slot,
	output pipe_pkg::exc_rec_t rec
);

	localparam pipe_pkg::fd_t fd_idle = '{
		pc: pc_initial,
		inst: pipe_pkg::nop_inst,
		psw: 1'b0,
		is_flush: 1'b0
	};

	always_ff @(posedge clk) begin
		if (reset) begin
			slot <= fd_idle;
			rec <= '0;
		end else if (flush) begin
			slot <= fd_idle;
			slot.is_flush <= 1'b1;
			rec <= '0;
		end else if (exc != pipe_pkg::exc_none) begin
			slot <= fd_idle;
			slot.psw <= slot_in.psw; // handler needs the mode of the faulting fetch.
			rec <= '{cause: exc, addr: slot_in.pc, epc: slot_in.pc};
		end else if (!stall) begin
			if (icache_stall) begin
				slot.inst <= pipe_pkg::nop_inst; // pc holds until the line arrives.
			end else begin
				slot <= slot_in;
				rec <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/pipe_latches.sv
// the four pipeline latches of the core; the datapath stages sit outside and drive every slot input.
`default_nettype none

module pipe_latches #(
	parameter pipe_pkg::word_t pc_initial = 32'h0000_1000
) (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic stall,
	input logic icache_stall,
	input logic hazard,
	input pipe_pkg::fd_t fd_in,
	input pipe_pkg::dx_t dx_in,
	input pipe_pkg::xm_t xm_in,
	input pipe_pkg::mw_t mw_in,
	input pipe_pkg::exc_e fd_exc,
	input pipe_pkg::exc_e dx_exc,
	input pipe_pkg::exc_e xm_exc,
	input pipe_pkg::exc_e mw_exc,
	input pipe_pkg::word_t mem_addr,
	output pipe_pkg::fd_t fd_out,
	output pipe_pkg::dx_t dx_out,
	output pipe_pkg::xm_t xm_out,
	output pipe_pkg::mw_t mw_out,
	output pipe_pkg::exc_rec_t fd_rec,
	output pipe_pkg::exc_rec_t dx_rec,
	output pipe_pkg::exc_rec_t xm_rec,
	output pipe_pkg::exc_rec_t mw_rec
);

	fetch_latch #(.pc_initial(pc_initial)) i_fetch_latch (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.stall(stall),
		.icache_stall(icache_stall),
		.exc(fd_exc),
		.slot_in(fd_in),
		.slot(fd_out),
		.rec(fd_rec)
	);

	decode_latch #(.pc_initial(pc_initial)) i_decode_latch (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.stall(stall),
		.hazard(hazard),
		.exc(dx_exc),
		.slot_in(dx_in),
		.rec_in(fd_rec),
		.slot(dx_out),
		.rec(dx_rec)
	);

	execute_latch #(.pc_initial(pc_initial)) i_execute_latch (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.stall(stall),
		.exc(xm_exc),
		.slot_in(xm_in),
		.rec_in(dx_rec),
		.slot(xm_out),
		.rec(xm_rec)
	);

	writeback_latch #(.pc_initial(pc_initial)) i_writeback_latch (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.stall(stall),
		.is_ecall(xm_in.is_ecall), // ecall flag rides beside the memory slot.
		.exc(mw_exc),
		.mem_addr(mem_addr),
		.slot_in(mw_in),
		.rec_in(xm_rec),
		.slot(mw_out),
		.rec(mw_rec)
	);

endmodule

`default_nettype wire

// File: verilog/pipe_pkg.sv
// shared types for a 32-bit five-stage core; exception causes are full words and zero means none.
`default_nettype none

package pipe_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	localparam word_t nop_inst = 32'h0000_0013; // addi x0, x0, 0.

	typedef enum logic [3:0] {
		alu_add = 4'd0,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_slt,
		alu_sltu,
		alu_mul
	} alu_op_e;

	typedef enum logic [2:0] {
		branch_none = 3'd0,
		branch_eq,
		branch_ne,
		branch_lt,
		branch_ge
	} branch_e;

	typedef enum logic [31:0] {
		exc_none = 32'd0,
		exc_itlb_miss = 32'd1,
		exc_dtlb_miss = 32'd2,
		exc_illegal = 32'd3,
		exc_ecall = 32'd4
	} exc_e;

	// cause is a plain word, ecall parks its result there.
	typedef struct packed {
		word_t cause;
		word_t addr;
		word_t epc;
	} exc_rec_t;

	typedef struct packed {
		alu_op_e alu_op;
		reg_addr_t rd;
		logic reg_write;
		logic mem_to_reg;
		logic mem_we;
		branch_e branch;
		logic is_jump;
		logic is_byte;
		logic is_ecall;
	} ctrl_t;

	localparam ctrl_t ctrl_idle = '{
		alu_op: alu_add,
		rd: 5'd0,
		reg_write: 1'b0,
		mem_to_reg: 1'b0,
		mem_we: 1'b0,
		branch: branch_none,
		is_jump: 1'b0,
		is_byte: 1'b0,
		is_ecall: 1'b0
	};

	typedef struct packed {
		word_t pc;
		word_t inst;
		logic psw;
		logic is_flush;
	} fd_t;

	typedef struct packed {
		word_t pc;
		word_t reg_a;
		word_t reg_b;
		word_t immed;
		ctrl_t ctrl;
		logic psw;
		logic is_flush;
	} dx_t;

	typedef struct packed {
		word_t pc;
		word_t result;
		word_t reg_b; // store data.
		reg_addr_t rd;
		logic reg_write;
		logic mem_to_reg;
		logic mem_we;
		logic is_byte;
		logic is_ecall;
		logic psw;
		logic is_flush;
	} xm_t;

	typedef struct packed {
		reg_addr_t rd;
		word_t result;
		word_t mem_data;
		logic reg_write;
		logic mem_to_reg;
		logic is_flush;
	} mw_t;

	// an older record wins, a new one only inherits the epc.
	function automatic exc_rec_t forward_exc(exc_rec_t rec_in, exc_e exc);
		exc_rec_t rec;
		if (rec_in.cause != '0) begin
			rec = rec_in;
		end else begin
			rec.cause = exc;
			rec.addr = '0;
			rec.epc = rec_in.epc;
		end
		return rec;
	endfunction

endpackage

`default_nettype wire

// File: verilog/writeback_latch.sv
// memory/writeback latch; only TLB-miss records reach the handler, ecall assumes 4-byte instructions.
`default_nettype none

module writeback_latch #(
	parameter pipe_pkg::word_t pc_initial = 32'h0000_1000
) (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic stall,
	input logic is_ecall,
	input pipe_pkg::exc_e exc,
	input pipe_pkg::word_t mem_addr,
	input pipe_pkg::mw_t slot_in,
	input pipe_pkg::exc_rec_t rec_in,
	output pipe_pkg::mw_t slot,
	output pipe_pkg::exc_rec_t rec
);

	localparam pipe_pkg::mw_t mw_idle = '{
		rd: 5'd0,
		result: 32'd0,
		mem_data: 32'd0,
		reg_write: 1'b0,
		mem_to_reg: 1'b0,
		is_flush: 1'b0
	};

	always_ff @(posedge clk) begin
		if (reset) begin
			slot <= mw_idle;
			rec <= '0;
		end else if (flush) begin
			slot <= mw_idle;
			slot.is_flush <= 1'b1;
			rec <= '0;
		end else if (exc != pipe_pkg::exc_none) begin
			slot <= mw_idle;
			if (rec_in.cause != '0) begin
				if (rec_in.cause == pipe_pkg::exc_itlb_miss) begin
					rec <= rec_in;
				end else begin
					rec <= '0;
				end
			end else if (exc == pipe_pkg::exc_itlb_miss || exc == pipe_pkg::exc_dtlb_miss) begin
				rec <= '{cause: exc, addr: mem_addr, epc: rec_in.epc}; // faulting data address.
			end else begin
				rec <= '0;
			end
		end else if (!stall) begin
			slot <= slot_in;
			if (is_ecall) begin
				// return past the call, result goes out in the cause word.
				rec <= '{cause: slot_in.result, addr: rec_in.addr, epc: rec_in.epc + 32'd4};
			end else begin
				rec <= rec_in;
			end
		end
	end

endmodule

`default_nettype wire
